// ==== build.f ====
source/input_port_pkg.sv
source/ss_bus_if.sv
source/input_cfg_if.sv
source/bus_connector.sv
source/input_lines.sv
source/input_port_regs.sv
source/input_port_top.sv
sim/input_port_assert.sv
sim/input_port_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and searches the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module input_port_tb -f build.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vinput_port_tb > sim.log 2>&1
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// ==== sim/input_port_assert.sv ====
`timescale 1ns/1ps

module input_port_assert (
  input logic clk,
  input logic reset_factor,
  input logic clk_en,
  input logic clear_factor,
  input logic bus_restore,
  input input_port_pkg::factor_t factor_flags
);

  // Reset wins over a restore and over any edge
  property flags_clear_in_reset;
    @(posedge clk) reset_factor |=> (factor_flags == 2'b00);
  endproperty

  // The flags are sticky until something clears or reloads them
  property flags_fall_only_on_clear;
    @(posedge clk) (!reset_factor && !clear_factor && !bus_restore)
      |=> ((factor_flags & $past(factor_flags)) == $past(factor_flags));
  endproperty

  property flags_hold_while_disabled;
    @(posedge clk) (!reset_factor && !clk_en && !bus_restore)
      |=> ((factor_flags & ~$past(factor_flags)) == 2'b00);
  endproperty

  assert property (flags_clear_in_reset)
    else $error("factor flags not cleared after reset_factor");
  assert property (flags_fall_only_on_clear)
    else $error("factor flag fell without reset, clear or restore");
  assert property (flags_hold_while_disabled)
    else $error("factor flag rose while clk_en was low");

endmodule

bind input_lines input_port_assert u_input_port_assert (
  .clk(clk),
  .reset_factor(reset_factor),
  .clk_en(clk_en),
  .clear_factor(cfg.clear_factor),
  .bus_restore(ss.bus_restore),
  .factor_flags(factor_flags)
);

// ==== sim/input_port_tb.sv ====
`timescale 1ns/1ps

module input_port_tb;
  import input_port_pkg::*;

  localparam int TIMEOUT_CYCLES = 3000;
  localparam logic [31:0] SEED = 32'd44216;

  logic clk;
  logic reset_factor;
  logic clk_en;
  nibble_t input_k0;
  nibble_t input_k1;
  reg_addr_t cpu_addr;
  nibble_t cpu_wdata;
  logic cpu_wren;
  logic cpu_rden;
  nibble_t cpu_rdata;
  factor_t factor_flags;
  ss_data_t ss_bus_in;
  ss_addr_t ss_bus_addr;
  logic ss_bus_wren;
  logic ss_bus_restore;
  ss_data_t ss_bus_out;

  int cycle_count;
  int check_count;
  logic [31:0] rng_state;

  // Reference model state for the random test
  nibble_t model_prev_k0;
  nibble_t model_prev_k1;
  nibble_t model_relation;
  nibble_t model_mask_k0;
  nibble_t model_mask_k1;
  factor_t model_flags;
  logic model_clear;

  input_port_top u_input_port_top (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > TIMEOUT_CYCLES) begin
      $display("TESTS FAILED");
      $fatal(1, "Timeout after %0d cycles without the tests finishing", TIMEOUT_CYCLES);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Relation 1 asks for a low new level on that K0 line, relation 0 for a high one
  function automatic factor_t model_edges(input nibble_t prev_k0, input nibble_t k0,
                                          input nibble_t prev_k1, input nibble_t k1);
    factor_t hits;
    hits = 2'b00;
    for (int i = 0; i < 4; i++) begin
      if (model_mask_k0[i] && (prev_k0[i] != k0[i]) && (k0[i] == !model_relation[i]))
        hits[0] = 1'b1;
      if (model_mask_k1[i] && prev_k1[i] && !k1[i])
        hits[1] = 1'b1;
    end
    return hits;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    assert (actual === expected)
      else begin
        $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
                 $time, name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "Stopping at the first failed check");
      end
  endtask

  // Inputs change 1 ns after the rising edge and outputs are sampled there
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic cpu_write(input reg_addr_t addr, input nibble_t data);
    cpu_addr = addr;
    cpu_wdata = data;
    cpu_wren = 1'b1;
    step();
    cpu_wren = 1'b0;
  endtask

  task automatic cpu_read(input reg_addr_t addr, output nibble_t data);
    cpu_addr = addr;
    cpu_rden = 1'b1;
    step();
    cpu_rden = 1'b0;
    data = cpu_rdata;
  endtask

  task automatic ss_write(input ss_addr_t addr, input ss_data_t data);
    ss_bus_addr = addr;
    ss_bus_in = data;
    ss_bus_wren = 1'b1;
    step();
    ss_bus_wren = 1'b0;
  endtask

  task automatic ss_read(input ss_addr_t addr, output ss_data_t data);
    ss_bus_addr = addr;
    #1;
    data = ss_bus_out;
  endtask

  task automatic ss_restore();
    ss_bus_restore = 1'b1;
    step();
    ss_bus_restore = 1'b0;
  endtask

  task automatic check_flags(input factor_t expected);
    check_value("factor_flags", 32'(expected), 32'(factor_flags));
  endtask

  task automatic check_reg(input reg_addr_t addr, input nibble_t expected);
    nibble_t data;
    cpu_read(addr, data);
    check_value("cpu_rdata", 32'(expected), 32'(data));
  endtask

  task automatic check_ss(input ss_addr_t addr, input ss_data_t expected);
    ss_data_t data;
    ss_read(addr, data);
    check_value("ss_bus_out", expected, data);
  endtask

  // The clear lands one edge after the read
  task automatic clear_flags();
    nibble_t data;
    cpu_read(REG_FACTOR, data);
    step();
  endtask

  task automatic random_cycle(input nibble_t k0, input nibble_t k1, input logic en,
                              input logic rd);
    factor_t set_now;
    factor_t flags_before;
    input_k0 = k0;
    input_k1 = k1;
    clk_en = en;
    cpu_addr = REG_FACTOR;
    cpu_rden = rd;
    set_now = en ? model_edges(model_prev_k0, k0, model_prev_k1, k1) : 2'b00;
    flags_before = model_flags;
    step();
    cpu_rden = 1'b0;
    model_flags = (model_clear ? 2'b00 : model_flags) | set_now;
    model_clear = rd;
    if (en) begin
      model_prev_k0 = k0;
      model_prev_k1 = k1;
    end
    check_flags(model_flags);
    if (rd)
      check_value("cpu_rdata", 32'(flags_before), 32'(cpu_rdata));
  endtask

  task automatic test_reset();
    check_flags(2'b00);
    check_value("cpu_rdata", 32'h0, 32'(cpu_rdata));
    for (int a = 0; a < 8; a++) begin
      check_reg(reg_addr_t'(a), 4'h0);
    end
    check_ss(SS_INPUT, '0);
    check_ss(SS_INPUT_CONFIG, '0);
  endtask

  task automatic test_k0_edges();
    cpu_write(REG_MASK_K0, 4'b0001);
    input_k0 = 4'b0001;
    step();
    check_flags(2'b01);
    clear_flags();
    input_k0 = 4'b0000;
    step();
    check_flags(2'b00);
    cpu_write(REG_RELATION_K0, 4'b0001);
    input_k0 = 4'b0001;
    step();
    check_flags(2'b00);
    input_k0 = 4'b0000;
    step();
    check_flags(2'b01);
    clear_flags();
    // Line 1 rises and falls and line 3 rises, all masked
    input_k0 = 4'b0010;
    step();
    input_k0 = 4'b1000;
    step();
    check_flags(2'b00);
    check_reg(REG_K0_DATA, 4'b1000);
  endtask

  task automatic test_k1_and_enable();
    cpu_write(REG_MASK_K1, 4'b0100);
    input_k1 = 4'b0100;
    step();
    check_flags(2'b00);
    check_reg(REG_K1_DATA, 4'b0100);
    input_k1 = 4'b0000;
    step();
    check_flags(2'b10);
    clear_flags();
    input_k1 = 4'b0001;
    step();
    input_k1 = 4'b0000;
    step();
    check_flags(2'b00);
    // Both ports toggle and return while nothing is sampled
    clk_en = 1'b0;
    input_k1 = 4'b0100;
    input_k0 = 4'b1001;
    step();
    input_k1 = 4'b0000;
    input_k0 = 4'b1000;
    step();
    clk_en = 1'b1;
    step();
    check_flags(2'b00);
  endtask

  task automatic test_random_edges();
    logic [31:0] r;
    clk_en = 1'b1;
    clear_flags();
    check_flags(2'b00);
    model_prev_k0 = input_k0;
    model_prev_k1 = input_k1;
    model_flags = 2'b00;
    model_clear = 1'b0;
    for (int i = 0; i < 200; i++) begin
      if (i % 50 == 0) begin
        random_cycle(input_k0, input_k1, 1'b0, 1'b0);
        rng_state = xorshift32(rng_state);
        r = rng_state;
        model_relation = r[3:0];
        model_mask_k0 = r[7:4];
        model_mask_k1 = r[11:8];
        cpu_write(REG_RELATION_K0, model_relation);
        cpu_write(REG_MASK_K0, model_mask_k0);
        cpu_write(REG_MASK_K1, model_mask_k1);
      end
      rng_state = xorshift32(rng_state);
      r = rng_state;
      random_cycle(r[3:0], r[7:4], r[8] | r[9], r[10] & r[11]);
    end
  endtask

  task automatic test_clear();
    clk_en = 1'b0;
    cpu_write(REG_RELATION_K0, 4'b0000);
    cpu_write(REG_MASK_K0, 4'b0001);
    cpu_write(REG_MASK_K1, 4'b0001);
    input_k0 = 4'b0000;
    input_k1 = 4'b1111;
    clk_en = 1'b1;
    step();
    clear_flags();
    check_flags(2'b00);
    input_k0 = 4'b0001;
    input_k1 = 4'b1110;
    step();
    check_reg(REG_FACTOR, 4'b0011);
    step();
    check_flags(2'b00);
    // The rising edge arrives on the clearing edge and is kept
    input_k0 = 4'b0000;
    check_reg(REG_FACTOR, 4'b0000);
    input_k0 = 4'b0001;
    step();
    check_flags(2'b01);
    reset_factor = 1'b1;
    step();
    reset_factor = 1'b0;
    check_flags(2'b00);
  endtask

  task automatic test_savestate();
    cpu_write(REG_RELATION_K0, 4'h5);
    cpu_write(REG_MASK_K0, 4'hA);
    cpu_write(REG_MASK_K1, 4'h3);
    input_k1 = 4'b1100;
    step();
    check_flags(2'b10);
    check_ss(SS_INPUT, 32'h0000_0002);
    check_ss(SS_INPUT_CONFIG, 32'h0000_03A5);
    ss_write(SS_INPUT, 32'h0000_0001);
    ss_write(SS_INPUT_CONFIG, 32'h0000_06CA);
    check_flags(2'b10);
    ss_restore();
    check_flags(2'b01);
    check_reg(REG_RELATION_K0, 4'hA);
    check_reg(REG_MASK_K0, 4'hC);
    check_reg(REG_MASK_K1, 4'h6);
    check_ss(SS_INPUT_CONFIG, 32'h0000_06CA);
    check_flags(2'b01);
  endtask

  initial begin
    reset_factor = 1'b1;
    clk_en = 1'b1;
    input_k0 = '0;
    input_k1 = '0;
    cpu_addr = '0;
    cpu_wdata = '0;
    cpu_wren = 1'b0;
    cpu_rden = 1'b0;
    ss_bus_in = '0;
    ss_bus_addr = '0;
    ss_bus_wren = 1'b0;
    ss_bus_restore = 1'b0;
    cycle_count = 0;
    check_count = 0;
    rng_state = SEED;
    repeat (4) @(posedge clk);
    #1;
    reset_factor = 1'b0;
    test_reset();
    test_k0_edges();
    test_k1_and_enable();
    test_random_edges();
    test_clear();
    test_savestate();
    if (check_count > 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("TESTS FAILED");
      $fatal(1, "No checks were run");
    end
  end

endmodule

// ==== source/bus_connector.sv ====
`timescale 1ns/1ps

module bus_connector #(
  parameter input_port_pkg::ss_addr_t ADDRESS = '0,
  parameter input_port_pkg::ss_data_t DEFAULT_VALUE = '0
) (
  input logic clk,
  input logic reset_factor,
  ss_bus_if.connector ss,
  input input_port_pkg::ss_data_t current_data,
  output input_port_pkg::ss_data_t new_data
);

  logic addr_match;

  assign addr_match = (ss.bus_addr == ADDRESS);

  // Holds the last word the host wrote here, the owner picks it up on restore
  always_ff @(posedge clk) begin
    if (reset_factor) begin
      new_data <= DEFAULT_VALUE;
    end else if (ss.bus_wren && addr_match) begin
      new_data <= ss.bus_in;
    end
  end

  // Only the matching connector puts data on the bus, so the chain is a plain OR
  assign ss.bus_out = (addr_match ? current_data : '0) | ss.chain_in;

endmodule

// ==== source/input_cfg_if.sv ====
`timescale 1ns/1ps

interface input_cfg_if;
  import input_port_pkg::*;

  nibble_t relation_k0;
  nibble_t mask_k0;
  nibble_t mask_k1;
  factor_t factor_flags;

  // One-cycle pulse after a CPU read of the factor register
  logic clear_factor;

  modport regs (
    output relation_k0,
    output mask_k0,
    output mask_k1,
    output clear_factor,
    input factor_flags
  );

  modport lines (
    input relation_k0,
    input mask_k0,
    input mask_k1,
    input clear_factor,
    output factor_flags
  );

endinterface

// ==== source/input_lines.sv ====
`timescale 1ns/1ps

module input_lines (
  input logic clk,
  input logic reset_factor,
  input logic clk_en,
  input input_port_pkg::nibble_t input_k0,
  input input_port_pkg::nibble_t input_k1,
  input_cfg_if.lines cfg,
  ss_bus_if.connector ss
);
  import input_port_pkg::*;

  nibble_t prev_input_k0;
  nibble_t prev_input_k1;
  nibble_t edge_k0;
  nibble_t edge_k1;
  factor_t set_flags;
  factor_t factor_flags;
  ss_data_t ss_current_data;
  ss_data_t ss_new_data;

  // A relation bit of 1 selects the falling edge on that K0 line
  assign edge_k0 = cfg.mask_k0 &
                   ((cfg.relation_k0 & prev_input_k0 & ~input_k0) |
                    (~cfg.relation_k0 & ~prev_input_k0 & input_k0));

  // K1 lines only ever see the falling edge
  assign edge_k1 = cfg.mask_k1 & prev_input_k1 & ~input_k1;

  assign set_flags = clk_en ? {|edge_k1, |edge_k0} : 2'b00;

  always_ff @(posedge clk) begin
    if (reset_factor) begin
      prev_input_k0 <= '0;
      prev_input_k1 <= '0;
    end else if (!ss.bus_restore && clk_en) begin
      prev_input_k0 <= input_k0;
      prev_input_k1 <= input_k1;
    end
  end

  // A new edge wins over the clear from the factor read
  always_ff @(posedge clk) begin
    if (reset_factor) begin
      factor_flags <= '0;
    end else if (ss.bus_restore) begin
      factor_flags <= ss_new_data[1:0];
    end else begin
      factor_flags <= (factor_flags & ~{2{cfg.clear_factor}}) | set_flags;
    end
  end

  assign cfg.factor_flags = factor_flags;

  assign ss_current_data = {30'b0, factor_flags};

  bus_connector #(
    .ADDRESS(SS_INPUT),
    .DEFAULT_VALUE('0)
  ) u_ss_connector (
    .clk(clk),
    .reset_factor(reset_factor),
    .ss(ss),
    .current_data(ss_current_data),
    .new_data(ss_new_data)
  );

endmodule

// ==== source/input_port_pkg.sv ====
package input_port_pkg;

  // One key port, or one relation or mask register
  typedef logic [3:0] nibble_t;

  // Bit 0 is the K0 factor, bit 1 the K1 factor
  typedef logic [1:0] factor_t;

  typedef logic [31:0] ss_data_t;
  typedef logic [7:0] ss_addr_t;
  typedef logic [2:0] reg_addr_t;

  // Savestate addresses of the two connectors in this block
  localparam ss_addr_t SS_INPUT = 8'h30;
  localparam ss_addr_t SS_INPUT_CONFIG = 8'h31;

  // CPU register map
  localparam reg_addr_t REG_K0_DATA = 3'd0;
  localparam reg_addr_t REG_K1_DATA = 3'd1;
  localparam reg_addr_t REG_RELATION_K0 = 3'd2;
  localparam reg_addr_t REG_MASK_K0 = 3'd3;
  localparam reg_addr_t REG_MASK_K1 = 3'd4;
  localparam reg_addr_t REG_FACTOR = 3'd5;

endpackage

// ==== source/input_port_regs.sv ====
`timescale 1ns/1ps

module input_port_regs (
  input logic clk,
  input logic reset_factor,
  input input_port_pkg::nibble_t input_k0,
  input input_port_pkg::nibble_t input_k1,
  input input_port_pkg::reg_addr_t cpu_addr,
  input input_port_pkg::nibble_t cpu_wdata,
  input logic cpu_wren,
  input logic cpu_rden,
  output input_port_pkg::nibble_t cpu_rdata,
  input_cfg_if.regs cfg,
  ss_bus_if.connector ss
);
  import input_port_pkg::*;

  nibble_t relation_k0;
  nibble_t mask_k0;
  nibble_t mask_k1;
  nibble_t read_data;
  logic clear_factor;
  ss_data_t ss_current_data;
  ss_data_t ss_new_data;

  // A restore overrides any CPU write to the configuration in the same cycle
  always_ff @(posedge clk) begin
    if (reset_factor) begin
      relation_k0 <= '0;
      mask_k0 <= '0;
      mask_k1 <= '0;
    end else if (ss.bus_restore) begin
      relation_k0 <= ss_new_data[3:0];
      mask_k0 <= ss_new_data[7:4];
      mask_k1 <= ss_new_data[11:8];
    end else if (cpu_wren) begin
      case (cpu_addr)
        REG_RELATION_K0: relation_k0 <= cpu_wdata;
        REG_MASK_K0: mask_k0 <= cpu_wdata;
        REG_MASK_K1: mask_k1 <= cpu_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (cpu_addr)
      REG_K0_DATA: read_data = input_k0;
      REG_K1_DATA: read_data = input_k1;
      REG_RELATION_K0: read_data = relation_k0;
      REG_MASK_K0: read_data = mask_k0;
      REG_MASK_K1: read_data = mask_k1;
      REG_FACTOR: read_data = {2'b00, cfg.factor_flags};
      default: read_data = '0;
    endcase
  end

  // Read data is held until the next read
  always_ff @(posedge clk) begin
    if (reset_factor) begin
      cpu_rdata <= '0;
    end else if (cpu_rden) begin
      cpu_rdata <= read_data;
    end
  end

  // The flags were sampled into cpu_rdata at this edge, so they clear one cycle later
  always_ff @(posedge clk) begin
    if (reset_factor) begin
      clear_factor <= 1'b0;
    end else begin
      clear_factor <= cpu_rden && (cpu_addr == REG_FACTOR);
    end
  end

  assign cfg.relation_k0 = relation_k0;
  assign cfg.mask_k0 = mask_k0;
  assign cfg.mask_k1 = mask_k1;
  assign cfg.clear_factor = clear_factor;

  assign ss_current_data = {20'b0, mask_k1, mask_k0, relation_k0};

  bus_connector #(
    .ADDRESS(SS_INPUT_CONFIG),
    .DEFAULT_VALUE('0)
  ) u_ss_connector (
    .clk(clk),
    .reset_factor(reset_factor),
    .ss(ss),
    .current_data(ss_current_data),
    .new_data(ss_new_data)
  );

endmodule

// ==== source/input_port_top.sv ====
`timescale 1ns/1ps

module input_port_top (
  input logic clk,
  input logic reset_factor,
  input logic clk_en,
  input input_port_pkg::nibble_t input_k0,
  input input_port_pkg::nibble_t input_k1,
  input input_port_pkg::reg_addr_t cpu_addr,
  input input_port_pkg::nibble_t cpu_wdata,
  input logic cpu_wren,
  input logic cpu_rden,
  output input_port_pkg::nibble_t cpu_rdata,
  output input_port_pkg::factor_t factor_flags,
  input input_port_pkg::ss_data_t ss_bus_in,
  input input_port_pkg::ss_addr_t ss_bus_addr,
  input logic ss_bus_wren,
  input logic ss_bus_restore,
  output input_port_pkg::ss_data_t ss_bus_out
);

  input_cfg_if cfg_if ();
  ss_bus_if ss_regs_if ();
  ss_bus_if ss_lines_if ();

  // Both connectors see the same host signals
  assign ss_regs_if.bus_in = ss_bus_in;
  assign ss_regs_if.bus_addr = ss_bus_addr;
  assign ss_regs_if.bus_wren = ss_bus_wren;
  assign ss_regs_if.bus_restore = ss_bus_restore;
  assign ss_lines_if.bus_in = ss_bus_in;
  assign ss_lines_if.bus_addr = ss_bus_addr;
  assign ss_lines_if.bus_wren = ss_bus_wren;
  assign ss_lines_if.bus_restore = ss_bus_restore;

  // Read chain runs regs first, then lines
  assign ss_regs_if.chain_in = '0;
  assign ss_lines_if.chain_in = ss_regs_if.bus_out;
  assign ss_bus_out = ss_lines_if.bus_out;

  assign factor_flags = cfg_if.factor_flags;

  input_port_regs u_input_port_regs (
    .clk(clk),
    .reset_factor(reset_factor),
    .input_k0(input_k0),
    .input_k1(input_k1),
    .cpu_addr(cpu_addr),
    .cpu_wdata(cpu_wdata),
    .cpu_wren(cpu_wren),
    .cpu_rden(cpu_rden),
    .cpu_rdata(cpu_rdata),
    .cfg(cfg_if.regs),
    .ss(ss_regs_if.connector)
  );

  input_lines u_input_lines (
    .clk(clk),
    .reset_factor(reset_factor),
    .clk_en(clk_en),
    .input_k0(input_k0),
    .input_k1(input_k1),
    .cfg(cfg_if.lines),
    .ss(ss_lines_if.connector)
  );

endmodule

// ==== source/ss_bus_if.sv ====
`timescale 1ns/1ps

interface ss_bus_if;
  import input_port_pkg::*;

  ss_data_t bus_in;
  ss_addr_t bus_addr;
  logic bus_wren;
  logic bus_restore;

  // Read data from the connector earlier in the chain
  ss_data_t chain_in;
  ss_data_t bus_out;

  modport host (
    output bus_in,
    output bus_addr,
    output bus_wren,
    output bus_restore,
    input bus_out
  );

  modport connector (
    input bus_in,
    input bus_addr,
    input bus_wren,
    input bus_restore,
    input chain_in,
    output bus_out
  );

endinterface
